// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
hw/lsu_pkg.sv
hw/mem_req_if.sv
hw/axi_lite_if.sv
hw/lsu_decode.sv
hw/lsu_axi_ctrl.sv
hw/lsu_load_ext.sv
hw/axi_sram.sv
hw/lsu_top.sv
verification/lsu_tb.sv

// ==== hw/axi_lite_if.sv ====
`timescale 1ns/1ps

interface axi_lite_if
    import lsu_pkg::*;
();

    // read address
    logic [XLEN-1:0]   araddr;
    logic              arvalid;
    logic              arready;

    // read data
    logic [XLEN-1:0]   rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    // write address
    logic [XLEN-1:0]   awaddr;
    logic              awvalid;
    logic              awready;

    // write data
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;

    // write response
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;

    modport master (
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready,
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready
    );

    modport slave (
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready,
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready
    );

endinterface

// ==== hw/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS   = 256,
    parameter int READY_DELAY = 2
) (
    input  logic      clk,
    input  logic      rst,
    axi_lite_if.slave axi
);

    localparam int         IDX_W = $clog2(MEM_WORDS);
    localparam logic [3:0] DELAY = 4'(READY_DELAY);

    logic [XLEN-1:0] mem [MEM_WORDS];
    sram_state_e     state;
    logic [3:0]      delay_cnt;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic            ar_fire;
    logic            wr_fire;

    // word index wraps at the array depth
    assign rd_idx = IDX_W'((axi.araddr >> 2) % MEM_WORDS);
    assign wr_idx = IDX_W'((axi.awaddr >> 2) % MEM_WORDS);

    always_comb begin
        axi.arready = (state == SRAM_RD_WAIT) && (delay_cnt == DELAY);
        axi.awready = (state == SRAM_WR_WAIT) && (delay_cnt == DELAY);
        axi.wready  = axi.awready;
        axi.rvalid  = (state == SRAM_RD_RESP);
        axi.bvalid  = (state == SRAM_WR_RESP);
        axi.rresp   = AXI_RESP_OKAY;
        axi.bresp   = AXI_RESP_OKAY;
    end

    assign ar_fire = axi.arvalid && axi.arready;
    assign wr_fire = axi.awvalid && axi.awready && axi.wvalid && axi.wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SRAM_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                SRAM_IDLE: begin
                    delay_cnt <= '0;
                    if (axi.arvalid) begin
                        state <= SRAM_RD_WAIT;
                    end else if (axi.awvalid && axi.wvalid) begin
                        state <= SRAM_WR_WAIT;
                    end
                end
                SRAM_RD_WAIT: begin
                    if (ar_fire) begin
                        state <= SRAM_RD_RESP;
                    end else if (delay_cnt != DELAY) begin
                        delay_cnt <= delay_cnt + 4'd1;
                    end
                end
                SRAM_WR_WAIT: begin
                    if (wr_fire) begin
                        state <= SRAM_WR_RESP;
                    end else if (delay_cnt != DELAY) begin
                        delay_cnt <= delay_cnt + 4'd1;
                    end
                end
                SRAM_RD_RESP: if (axi.rready) state <= SRAM_IDLE;
                SRAM_WR_RESP: if (axi.bready) state <= SRAM_IDLE;
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    // byte-strobed write, array cleared on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (axi.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= axi.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            axi.rdata <= mem[rd_idx];
        end
    end

endmodule

// ==== hw/lsu_axi_ctrl.sv ====
`timescale 1ns/1ps

module lsu_axi_ctrl
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    mem_req_if.sink         req,
    output logic [XLEN-1:0] mem_r,
    output logic            finish,
    axi_lite_if.master      axi
);

    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic w_fire;
    logic b_fire;

    assign ar_fire = axi.arvalid && axi.arready;
    assign r_fire  = axi.rvalid && axi.rready;
    assign aw_fire = axi.awvalid && axi.awready;
    assign w_fire  = axi.wvalid && axi.wready;
    assign b_fire  = axi.bvalid && axi.bready;

    // read address channel
    always_ff @(posedge clk) begin
        if (req.r_en) begin
            axi.araddr <= req.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.arvalid <= 1'b0;
        end else if (ar_fire) begin
            axi.arvalid <= 1'b0;
        end else if (req.r_en) begin
            axi.arvalid <= 1'b1;
        end
    end

    // read data, shifted down to lane 0
    always_ff @(posedge clk) begin
        if (r_fire) begin
            mem_r <= axi.rdata >> {axi.araddr[1:0], 3'b000};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.rready <= 1'b0;
        end else if (r_fire) begin
            axi.rready <= 1'b0;
        end else if (ar_fire) begin
            axi.rready <= 1'b1;
        end
    end

    // write address channel
    always_ff @(posedge clk) begin
        if (req.w_en) begin
            axi.awaddr <= req.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.awvalid <= 1'b0;
        end else if (aw_fire) begin
            axi.awvalid <= 1'b0;
        end else if (req.w_en) begin
            axi.awvalid <= 1'b1;
        end
    end

    // write data, moved up into byte lanes
    always_ff @(posedge clk) begin
        if (req.w_en) begin
            axi.wdata <= req.wdata << {req.addr[1:0], 3'b000};
            axi.wstrb <= req.mask << req.addr[1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.wvalid <= 1'b0;
        end else if (w_fire) begin
            axi.wvalid <= 1'b0;
        end else if (req.w_en) begin
            axi.wvalid <= 1'b1;
        end
    end

    // write response channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.bready <= 1'b0;
        end else if (b_fire) begin
            axi.bready <= 1'b0;
        end else if (aw_fire) begin
            axi.bready <= 1'b1;
        end
    end

    // one cycle after either response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= r_fire || b_fire;
        end
    end

endmodule

// ==== hw/lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  lsu_op_e          req_op,
    input  logic [XLEN-1:0]  base,
    input  logic [XLEN-1:0]  offset,
    input  logic [XLEN-1:0]  store_data,
    input  logic             done,
    output logic             busy,
    output lsu_op_e          op,
    mem_req_if.source        req
);

    logic              accept;
    logic              is_store;
    logic [STRB_W-1:0] mask_next;

    // requests while busy are dropped
    assign accept = req_valid && !busy;

    always_comb begin
        is_store = 1'b0;
        case (req_op)
            LSU_LB, LSU_LBU: mask_next = 4'b0001;
            LSU_LH, LSU_LHU: mask_next = 4'b0011;
            LSU_LW:          mask_next = 4'b1111;
            LSU_SB: begin
                mask_next = 4'b0001;
                is_store  = 1'b1;
            end
            LSU_SH: begin
                mask_next = 4'b0011;
                is_store  = 1'b1;
            end
            default: begin
                mask_next = 4'b1111;
                is_store  = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            op       <= LSU_LW;
            req.r_en <= 1'b0;
            req.w_en <= 1'b0;
        end else begin
            req.r_en <= accept && !is_store;
            req.w_en <= accept && is_store;
            if (accept) begin
                busy <= 1'b1;
                op   <= req_op;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr  <= base + offset;
            req.wdata <= store_data;
            req.mask  <= mask_next;
        end
    end

endmodule

// ==== hw/lsu_load_ext.sv ====
`timescale 1ns/1ps

module lsu_load_ext
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  lsu_op_e         op,
    input  logic [XLEN-1:0] mem_r,
    input  logic            finish,
    output logic [XLEN-1:0] load_data,
    output logic            done
);

    logic [XLEN-1:0] ext_data;
    logic            is_load;

    always_comb begin
        is_load = 1'b1;
        case (op)
            LSU_LB:  ext_data = {{(XLEN-8){mem_r[7]}}, mem_r[7:0]};
            LSU_LH:  ext_data = {{(XLEN-16){mem_r[15]}}, mem_r[15:0]};
            LSU_LBU: ext_data = {{(XLEN-8){1'b0}}, mem_r[7:0]};
            LSU_LHU: ext_data = {{(XLEN-16){1'b0}}, mem_r[15:0]};
            LSU_LW:  ext_data = mem_r;
            default: begin
                // stores leave load_data alone
                ext_data = mem_r;
                is_load  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (finish && is_load) begin
            load_data <= ext_data;
        end
    end

endmodule

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;
    localparam int STRB_W = XLEN / 8;

    // access width, direction and signedness
    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

    // memory model states
    typedef enum logic [2:0] {
        SRAM_IDLE    = 3'd0,
        SRAM_RD_WAIT = 3'd1,
        SRAM_RD_RESP = 3'd2,
        SRAM_WR_WAIT = 3'd3,
        SRAM_WR_RESP = 3'd4
    } sram_state_e;

    // only response the memory ever gives
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS   = 256,
    parameter int READY_DELAY = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  lsu_op_e         req_op,
    input  logic [XLEN-1:0] base,
    input  logic [XLEN-1:0] offset,
    input  logic [XLEN-1:0] store_data,
    output logic            busy,
    output logic [XLEN-1:0] load_data,
    output logic            done
);

    lsu_op_e         op;
    logic [XLEN-1:0] mem_r;
    logic            finish;

    mem_req_if  req_bus ();
    axi_lite_if axi_bus ();

    lsu_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .done       (done),
        .busy       (busy),
        .op         (op),
        .req        (req_bus.source)
    );

    lsu_axi_ctrl u_axi_ctrl (
        .clk    (clk),
        .rst    (rst),
        .req    (req_bus.sink),
        .mem_r  (mem_r),
        .finish (finish),
        .axi    (axi_bus.master)
    );

    lsu_load_ext u_load_ext (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .mem_r     (mem_r),
        .finish    (finish),
        .load_data (load_data),
        .done      (done)
    );

    // memory behind the bus
    axi_sram #(
        .MEM_WORDS   (MEM_WORDS),
        .READY_DELAY (READY_DELAY)
    ) u_sram (
        .clk (clk),
        .rst (rst),
        .axi (axi_bus.slave)
    );

endmodule

// ==== hw/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if
    import lsu_pkg::*;
();

    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] mask;
    // one-cycle strobes, never both high
    logic              r_en;
    logic              w_en;

    modport source (
        output addr,
        output wdata,
        output mask,
        output r_en,
        output w_en
    );

    modport sink (
        input addr,
        input wdata,
        input mask,
        input r_en,
        input w_en
    );

endinterface

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int MEM_WORDS     = 256;
    localparam int BYTE_IDX_W    = $clog2(MEM_WORDS * STRB_W);
    localparam int DONE_TIMEOUT  = 50;
    localparam int RANDOM_COUNT  = 200;
    // every request of every test including the ignored pulse
    localparam int NUM_REQUESTS  = 8 + 13 + 7 + 6 + 4 + RANDOM_COUNT;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 60 + 200;
    localparam logic [31:0] SEED = 32'hddb4_400e;

    logic            clk;
    logic            rst;
    logic            req_valid;
    lsu_op_e         req_op;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] offset;
    logic [XLEN-1:0] store_data;
    logic            busy;
    logic [XLEN-1:0] load_data;
    logic            done;

    // byte-wide mirror of the memory
    logic [7:0]      ref_mem [MEM_WORDS * STRB_W];
    logic [31:0]     lcg_state = SEED;
    // last load result, which stores must leave in place
    logic [XLEN-1:0] last_load;
    logic            have_load = 1'b0;
    int              mismatch_errors = 0;
    int              timeout_errors = 0;

    lsu_top #(
        .MEM_WORDS   (MEM_WORDS),
        .READY_DELAY (2)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .busy       (busy),
        .load_data  (load_data),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int access_bytes(lsu_op_e op);
        case (op)
            LSU_LB, LSU_LBU, LSU_SB: return 1;
            LSU_LH, LSU_LHU, LSU_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_load_op(lsu_op_e op);
        case (op)
            LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // expected load value by width and sign
    function automatic logic [XLEN-1:0] predict_load(lsu_op_e op, logic [XLEN-1:0] addr);
        logic [XLEN-1:0]       raw;
        logic [BYTE_IDX_W-1:0] idx;
        int                    k;
        raw = '0;
        for (k = 0; k < access_bytes(op); k++) begin
            idx = addr[BYTE_IDX_W-1:0] + BYTE_IDX_W'(k);
            raw[8*k +: 8] = ref_mem[idx];
        end
        if (op == LSU_LB && raw[7]) begin
            raw[XLEN-1:8] = '1;
        end
        if (op == LSU_LH && raw[15]) begin
            raw[XLEN-1:16] = '1;
        end
        return raw;
    endfunction

    task automatic store_model(lsu_op_e op, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
        logic [BYTE_IDX_W-1:0] idx;
        int                    k;
        for (k = 0; k < access_bytes(op); k++) begin
            idx = addr[BYTE_IDX_W-1:0] + BYTE_IDX_W'(k);
            ref_mem[idx] = data[8*k +: 8];
        end
    endtask

    task automatic check_data(logic [XLEN-1:0] actual, logic [XLEN-1:0] expected, string what);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s, got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic drive_request(lsu_op_e op, logic [XLEN-1:0] base_v,
                                 logic [XLEN-1:0] offset_v, logic [XLEN-1:0] data_v);
        req_op     = op;
        base       = base_v;
        offset     = offset_v;
        store_data = data_v;
        req_valid  = 1'b1;
        @(negedge clk);
        req_valid  = 1'b0;
        check_flag(busy, 1'b1, "busy the cycle after acceptance");
    endtask

    // wait for done then check a load or record a store
    task automatic await_result(lsu_op_e op, logic [XLEN-1:0] addr, logic [XLEN-1:0] data);
        int              waited;
        logic [XLEN-1:0] expected;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            timeout_errors++;
            $display("No done pulse within %0d cycles for %s at address %h",
                     DONE_TIMEOUT, op.name(), addr);
        end else if (is_load_op(op)) begin
            expected = predict_load(op, addr);
            check_data(load_data, expected,
                       $sformatf("%s from %h", op.name(), addr));
            last_load = expected;
            have_load = 1'b1;
        end else begin
            if (have_load) begin
                check_data(load_data, last_load,
                           $sformatf("load_data held across %s to %h", op.name(), addr));
            end
            store_model(op, addr, data);
        end
        @(negedge clk);
        check_flag(done, 1'b0, "done lasts one cycle");
    endtask

    task automatic do_access(lsu_op_e op, logic [XLEN-1:0] base_v,
                             logic [XLEN-1:0] offset_v, logic [XLEN-1:0] data_v);
        check_flag(busy, 1'b0, "busy before request");
        drive_request(op, base_v, offset_v, data_v);
        await_result(op, base_v + offset_v, data_v);
    endtask

    task automatic word_round_trip();
        logic [XLEN-1:0] addrs [4];
        logic [XLEN-1:0] words [4];
        int              k;
        addrs = '{32'h000, 32'h004, 32'h040, 32'h3fc};
        words = '{32'h1234_5678, 32'hdead_beef, 32'h8000_0001, 32'hffff_0000};
        for (k = 0; k < 4; k++) begin
            do_access(LSU_SW, addrs[k], 32'd0, words[k]);
        end
        // offset path through the address adder
        for (k = 0; k < 4; k++) begin
            do_access(LSU_LW, addrs[k] - 32'h10, 32'h10, 32'd0);
        end
    endtask

    task automatic byte_lanes();
        logic [7:0] vals [4];
        int         k;
        vals = '{8'h81, 8'ha5, 8'hc3, 8'hf0};
        for (k = 0; k < 4; k++) begin
            do_access(LSU_SB, 32'h100, XLEN'(k), {24'hdead_be, vals[k]});
        end
        for (k = 0; k < 4; k++) begin
            do_access(LSU_LB, 32'h100, XLEN'(k), 32'd0);
            do_access(LSU_LBU, 32'h100, XLEN'(k), 32'd0);
        end
        do_access(LSU_LW, 32'h100, 32'd0, 32'd0);
    endtask

    task automatic halfwords();
        int k;
        do_access(LSU_SH, 32'h200, 32'd0, 32'h5555_8001);
        do_access(LSU_SH, 32'h200, 32'd2, 32'haaaa_fedc);
        for (k = 0; k < 2; k++) begin
            do_access(LSU_LH, 32'h200, XLEN'(2 * k), 32'd0);
            do_access(LSU_LHU, 32'h200, XLEN'(2 * k), 32'd0);
        end
        do_access(LSU_LW, 32'h200, 32'd0, 32'd0);
    endtask

    task automatic partial_write();
        do_access(LSU_SW, 32'h300, 32'd0, 32'h1234_5678);
        do_access(LSU_SB, 32'h300, 32'd1, 32'h0000_00ab);
        do_access(LSU_LW, 32'h300, 32'd0, 32'd0);
        do_access(LSU_SW, 32'h304, 32'd0, 32'h89ab_cdef);
        do_access(LSU_SH, 32'h304, 32'd2, 32'h0000_7e57);
        do_access(LSU_LW, 32'h304, 32'd0, 32'd0);
    endtask

    task automatic ignored_while_busy();
        logic extra_done;
        do_access(LSU_SW, 32'h380, 32'd0, 32'h600d_cafe);
        check_flag(busy, 1'b0, "busy before request");
        drive_request(LSU_LW, 32'h380, 32'd0, 32'd0);
        // store pulse that must be dropped
        req_op     = LSU_SW;
        store_data = 32'hbad0_bad0;
        req_valid  = 1'b1;
        @(negedge clk);
        req_valid  = 1'b0;
        await_result(LSU_LW, 32'h380, 32'd0);
        extra_done = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (done) begin
                extra_done = 1'b1;
            end
        end
        check_flag(extra_done, 1'b0, "done from ignored request");
        do_access(LSU_LW, 32'h380, 32'd0, 32'd0);
    endtask

    task automatic random_mix();
        lsu_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] off;
        int              n;
        for (n = 0; n < RANDOM_COUNT; n++) begin
            lcg_state = lcg_next(lcg_state);
            op = lsu_op_e'(lcg_state[30:28]);
            lcg_state = lcg_next(lcg_state);
            addr = XLEN'(lcg_state[25:16]);
            addr = addr & ~XLEN'(access_bytes(op) - 1);
            off = XLEN'(lcg_state[31:26]);
            lcg_state = lcg_next(lcg_state);
            do_access(op, addr - off, off, lcg_state);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        report_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = LSU_LW;
        base       = '0;
        offset     = '0;
        store_data = '0;
        for (int i = 0; i < MEM_WORDS * STRB_W; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        word_round_trip();
        byte_lanes();
        halfwords();
        partial_write();
        ignored_while_busy();
        random_mix();
        report_counts();
        if (mismatch_errors + timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
